//--- mcpu_core_pkg.sv
/*
 * Core register slice shared definitions.
 * Lane, register and predicate counts, plus the vector types
 * that travel between writeback, register file and operand fetch.
 */

package mcpu_core_pkg;

   // Fixed by the instruction set.
   localparam int NUM_LANES = 4;
   localparam int NUM_REGS  = 32;
   localparam int NUM_PREDS = 3;

   typedef logic [31:0]                   word_t;
   typedef logic [$clog2(NUM_REGS)-1:0]   reg_num_t;
   typedef logic [NUM_PREDS-1:0]          pred_vec_t;
   typedef logic [1:0]                    guard_t;

   // Guard codes 0..2 select a predicate; this one means unconditional.
   localparam guard_t GUARD_ALWAYS = 2'd3;

endpackage

//--- mcpu_core_writeback.sv
/*
 * Writeback stage.
 * Tests each lane's guard against the committed predicates, splits the
 * surviving result into a register or predicate write, and registers it.
 */

`timescale 1ns/1ps

module mcpu_core_writeback import mcpu_core_pkg::*; (
   input  logic      clkrst_core_clk,
   input  logic      clkrst_core_rst_n,
   input  logic      ex_valid      [NUM_LANES],
   input  logic      ex_pred_write [NUM_LANES],
   input  reg_num_t  ex_rd_num     [NUM_LANES],
   input  word_t     ex_rd_data    [NUM_LANES],
   input  guard_t    ex_guard      [NUM_LANES],
   input  pred_vec_t preds,
   output logic      wb_rd_we      [NUM_LANES],
   output logic      wb_pred_we    [NUM_LANES],
   output reg_num_t  wb_rd_num     [NUM_LANES],
   output word_t     wb_rd_data    [NUM_LANES]
);

   logic [NUM_PREDS:0] guard_tab;
   logic               rd_we_d   [NUM_LANES];
   logic               pred_we_d [NUM_LANES];

   // Guard lookup table, the top entry is the unconditional code.
   always_comb begin
      guard_tab[NUM_PREDS-1:0] = preds;
      guard_tab[GUARD_ALWAYS]  = 1'b1;
   end

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         logic keep;
         keep = ex_valid[i] && guard_tab[ex_guard[i]];
         rd_we_d[i] = keep && !ex_pred_write[i];
         // Predicate numbers 3 and up do not exist.
         pred_we_d[i] = keep && ex_pred_write[i] && (ex_rd_num[i][1:0] < NUM_PREDS);
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            wb_rd_we[i]   <= 1'b0;
            wb_pred_we[i] <= 1'b0;
         end
      end else begin
         for (int i = 0; i < NUM_LANES; i++) begin
            wb_rd_we[i]   <= rd_we_d[i];
            wb_pred_we[i] <= pred_we_d[i];
         end
      end
   end

   // Result payload.
   always_ff @(posedge clkrst_core_clk) begin
      for (int i = 0; i < NUM_LANES; i++) begin
         wb_rd_num[i]  <= ex_rd_num[i];
         wb_rd_data[i] <= ex_rd_data[i];
      end
   end

endmodule

//--- mcpu_core_regfile.sv
/*
 * General register file and predicate registers.
 * Four write ports with lower lane priority, eight combinational reads.
 */

`timescale 1ns/1ps

module mcpu_core_regfile import mcpu_core_pkg::*; (
   input  logic      clkrst_core_clk,
   input  logic      clkrst_core_rst_n,
   input  logic      wb_rd_we   [NUM_LANES],
   input  logic      wb_pred_we [NUM_LANES],
   input  reg_num_t  wb_rd_num  [NUM_LANES],
   input  word_t     wb_rd_data [NUM_LANES],
   input  reg_num_t  rf_rs_num  [NUM_LANES],
   input  reg_num_t  rf_rt_num  [NUM_LANES],
   output word_t     rs_data    [NUM_LANES],
   output word_t     rt_data    [NUM_LANES],
   output pred_vec_t preds,
   output word_t     r0
);

   word_t mem [NUM_REGS];

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            mem[r] <= '0;
         end
         preds <= '0;
      end else begin
         // Highest lane first so the lowest lane lands last and wins.
         for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (wb_rd_we[i]) begin
               mem[wb_rd_num[i]] <= wb_rd_data[i];
            end
            if (wb_pred_we[i]) begin
               preds[wb_rd_num[i][1:0]] <= wb_rd_data[i][0];
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         rs_data[i] = mem[rf_rs_num[i]];
         rt_data[i] = mem[rf_rt_num[i]];
      end
   end

   // Debug view of r0, which is an ordinary register here.
   assign r0 = mem[0];

endmodule

//--- mcpu_core_operand_fetch.sv
/*
 * Operand fetch stage.
 * Reads two sources per lane, forwards writes still in writeback
 * over the register file contents, and registers the operands.
 */

`timescale 1ns/1ps

module mcpu_core_operand_fetch import mcpu_core_pkg::*; (
   input  logic     clkrst_core_clk,
   input  logic     clkrst_core_rst_n,
   input  logic     dec_valid,
   input  reg_num_t dec_rs_num [NUM_LANES],
   input  reg_num_t dec_rt_num [NUM_LANES],
   input  word_t    rs_data    [NUM_LANES],
   input  word_t    rt_data    [NUM_LANES],
   input  logic     wb_rd_we   [NUM_LANES],
   input  reg_num_t wb_rd_num  [NUM_LANES],
   input  word_t    wb_rd_data [NUM_LANES],
   output reg_num_t rf_rs_num  [NUM_LANES],
   output reg_num_t rf_rt_num  [NUM_LANES],
   output logic     op_valid,
   output word_t    op_rs_data [NUM_LANES],
   output word_t    op_rt_data [NUM_LANES]
);

   word_t fwd_rs [NUM_LANES];
   word_t fwd_rt [NUM_LANES];

   // Register value after the writes pending in writeback commit.
   function automatic word_t forward(input reg_num_t num, input word_t rf_val);
      word_t val;
      val = rf_val;
      // Scan from the top lane down, lowest matching lane wins.
      for (int j = NUM_LANES - 1; j >= 0; j--) begin
         if (wb_rd_we[j] && (wb_rd_num[j] == num)) begin
            val = wb_rd_data[j];
         end
      end
      return val;
   endfunction

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         rf_rs_num[i] = dec_rs_num[i];
         rf_rt_num[i] = dec_rt_num[i];
         fwd_rs[i]    = forward(dec_rs_num[i], rs_data[i]);
         fwd_rt[i]    = forward(dec_rt_num[i], rt_data[i]);
      end
   end

   always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
      if (!clkrst_core_rst_n) begin
         op_valid <= 1'b0;
      end else begin
         op_valid <= dec_valid;
      end
   end

   // Operands only move on a decode strobe.
   always_ff @(posedge clkrst_core_clk) begin
      if (dec_valid) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            op_rs_data[i] <= fwd_rs[i];
            op_rt_data[i] <= fwd_rt[i];
         end
      end
   end

endmodule

//--- mcpu_core_regs_top.sv
/*
 * Register slice of the four-lane core.
 * Writeback, register file and operand fetch.
 */

`timescale 1ns/1ps

module mcpu_core_regs_top import mcpu_core_pkg::*; (
   input  logic      clkrst_core_clk,
   input  logic      clkrst_core_rst_n,
   input  logic      ex_valid      [NUM_LANES],
   input  reg_num_t  ex_rd_num     [NUM_LANES],
   input  word_t     ex_rd_data    [NUM_LANES],
   input  logic      ex_pred_write [NUM_LANES],
   input  guard_t    ex_guard      [NUM_LANES],
   input  logic      dec_valid,
   input  reg_num_t  dec_rs_num    [NUM_LANES],
   input  reg_num_t  dec_rt_num    [NUM_LANES],
   output logic      op_valid,
   output word_t     op_rs_data    [NUM_LANES],
   output word_t     op_rt_data    [NUM_LANES],
   output pred_vec_t preds,
   output word_t     r0
);

   logic     wb_rd_we   [NUM_LANES];
   logic     wb_pred_we [NUM_LANES];
   reg_num_t wb_rd_num  [NUM_LANES];
   word_t    wb_rd_data [NUM_LANES];
   reg_num_t rf_rs_num  [NUM_LANES];
   reg_num_t rf_rt_num  [NUM_LANES];
   word_t    rs_data    [NUM_LANES];
   word_t    rt_data    [NUM_LANES];

   mcpu_core_writeback mcpu_core_writeback_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .ex_valid          (ex_valid),
      .ex_pred_write     (ex_pred_write),
      .ex_rd_num         (ex_rd_num),
      .ex_rd_data        (ex_rd_data),
      .ex_guard          (ex_guard),
      .preds             (preds),
      .wb_rd_we          (wb_rd_we),
      .wb_pred_we        (wb_pred_we),
      .wb_rd_num         (wb_rd_num),
      .wb_rd_data        (wb_rd_data)
   );

   mcpu_core_regfile mcpu_core_regfile_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .wb_rd_we          (wb_rd_we),
      .wb_pred_we        (wb_pred_we),
      .wb_rd_num         (wb_rd_num),
      .wb_rd_data        (wb_rd_data),
      .rf_rs_num         (rf_rs_num),
      .rf_rt_num         (rf_rt_num),
      .rs_data           (rs_data),
      .rt_data           (rt_data),
      .preds             (preds),
      .r0                (r0)
   );

   mcpu_core_operand_fetch mcpu_core_operand_fetch_i (
      .clkrst_core_clk   (clkrst_core_clk),
      .clkrst_core_rst_n (clkrst_core_rst_n),
      .dec_valid         (dec_valid),
      .dec_rs_num        (dec_rs_num),
      .dec_rt_num        (dec_rt_num),
      .rs_data           (rs_data),
      .rt_data           (rt_data),
      .wb_rd_we          (wb_rd_we),
      .wb_rd_num         (wb_rd_num),
      .wb_rd_data        (wb_rd_data),
      .rf_rs_num         (rf_rs_num),
      .rf_rt_num         (rf_rt_num),
      .op_valid          (op_valid),
      .op_rs_data        (op_rs_data),
      .op_rt_data        (op_rt_data)
   );

endmodule

//--- mcpu_core_regs_properties.sv
/*
 * Writeback stage properties.
 * Reset state of the write enables and gating by ex_valid.
 */

`timescale 1ns/1ps

module mcpu_core_regs_properties import mcpu_core_pkg::*; (
   input logic clkrst_core_clk,
   input logic clkrst_core_rst_n,
   input logic ex_valid   [NUM_LANES],
   input logic wb_rd_we   [NUM_LANES],
   input logic wb_pred_we [NUM_LANES]
);

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      // Enables stay low while reset is held.
      a_reset_quiet: assert property (@(posedge clkrst_core_clk)
         !clkrst_core_rst_n |-> (!wb_rd_we[i] && !wb_pred_we[i]))
         else $error("lane %0d write enable high during reset", i);

      // No result, no write.
      a_valid_gate: assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
         !ex_valid[i] |=> (!wb_rd_we[i] && !wb_pred_we[i]))
         else $error("lane %0d wrote without a valid result", i);
   end

endmodule

bind mcpu_core_writeback mcpu_core_regs_properties mcpu_core_regs_properties_i (
   .clkrst_core_clk   (clkrst_core_clk),
   .clkrst_core_rst_n (clkrst_core_rst_n),
   .ex_valid          (ex_valid),
   .wb_rd_we          (wb_rd_we),
   .wb_pred_we        (wb_pred_we)
);

//--- tb_mcpu_core_regs.sv
/*
 * Directed testbench for the core register slice.
 * Drives execute results and decode reads, keeps a model of registers
 * and predicates, and compares every operand, preds and r0 against it.
 */

`timescale 1ns/1ps

module tb_mcpu_core_regs import mcpu_core_pkg::*; ();

   localparam int CYCLE_LIMIT = 2000;

   logic      clkrst_core_clk;
   logic      clkrst_core_rst_n;
   logic      ex_valid      [NUM_LANES];
   reg_num_t  ex_rd_num     [NUM_LANES];
   word_t     ex_rd_data    [NUM_LANES];
   logic      ex_pred_write [NUM_LANES];
   guard_t    ex_guard      [NUM_LANES];
   logic      dec_valid;
   reg_num_t  dec_rs_num    [NUM_LANES];
   reg_num_t  dec_rt_num    [NUM_LANES];
   logic      op_valid;
   word_t     op_rs_data    [NUM_LANES];
   word_t     op_rt_data    [NUM_LANES];
   pred_vec_t preds;
   word_t     r0;

   // Model state: committed contents, writes in writeback, expected operands.
   word_t     m_regs [NUM_REGS];
   pred_vec_t m_preds;
   logic      p_rd_we [NUM_LANES];
   logic      p_pred_we [NUM_LANES];
   reg_num_t  p_num [NUM_LANES];
   word_t     p_data [NUM_LANES];
   logic      e_valid;
   word_t     e_rs [NUM_LANES];
   word_t     e_rt [NUM_LANES];

   // Outputs captured mid-cycle by the last tick.
   word_t     got_rs [NUM_LANES];
   word_t     got_rt [NUM_LANES];
   pred_vec_t got_preds;
   word_t     got_r0;

   int        cycle_count = 0;
   logic      fail_reported = 1'b0;
   logic      pass_printed = 1'b0;

   mcpu_core_regs_top mcpu_core_regs_top_i (.*);

   initial begin
      clkrst_core_clk = 1'b0;
      forever #2 clkrst_core_clk = ~clkrst_core_clk;
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      fail_reported = 1'b1;
      $display("test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         report_error($sformatf("Fail %s expected 0x%08h got 0x%08h", name, exp, act));
      end
   endtask

   task automatic check_preds(input string name, input pred_vec_t exp, input pred_vec_t act);
      if (act !== exp) begin
         report_error($sformatf("Fail %s expected 0x%01h got 0x%01h", name, exp, act));
      end
   endtask

   always @(posedge clkrst_core_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         report_error($sformatf("Timeout, the tests ran past %0d cycles", CYCLE_LIMIT));
      end
   end

   // Advance the model by one clock edge with the inputs now on the DUT.
   task automatic model_step();
      word_t              nxt [NUM_REGS];
      pred_vec_t          nxt_p;
      logic [NUM_REGS-1:0]  done_r;
      logic [NUM_PREDS-1:0] done_p;
      logic               keep;
      nxt    = m_regs;
      nxt_p  = m_preds;
      done_r = '0;
      done_p = '0;
      // The first lane to claim a register owns it this cycle.
      for (int i = 0; i < NUM_LANES; i++) begin
         if (p_rd_we[i] && !done_r[p_num[i]]) begin
            nxt[p_num[i]]    = p_data[i];
            done_r[p_num[i]] = 1'b1;
         end
         if (p_pred_we[i] && !done_p[p_num[i][1:0]]) begin
            nxt_p[p_num[i][1:0]]  = p_data[i][0];
            done_p[p_num[i][1:0]] = 1'b1;
         end
      end
      e_valid = dec_valid;
      for (int i = 0; i < NUM_LANES; i++) begin
         if (dec_valid) begin
            e_rs[i] = nxt[dec_rs_num[i]];
            e_rt[i] = nxt[dec_rt_num[i]];
         end
         // Guards see the predicates committed before this edge.
         if (ex_guard[i] == GUARD_ALWAYS) begin
            keep = ex_valid[i];
         end else begin
            keep = ex_valid[i] && m_preds[ex_guard[i]];
         end
         p_rd_we[i]   = keep && !ex_pred_write[i];
         p_pred_we[i] = keep && ex_pred_write[i] && (ex_rd_num[i][1:0] != 2'd3);
         p_num[i]     = ex_rd_num[i];
         p_data[i]    = ex_rd_data[i];
      end
      m_regs  = nxt;
      m_preds = nxt_p;
   endtask

   // Check and capture at the falling edge, then step the model at the rising edge.
   task automatic tick();
      @(negedge clkrst_core_clk);
      check_preds("preds", m_preds, preds);
      check_word("r0", m_regs[0], r0);
      if (e_valid && !op_valid) begin
         report_error("op_valid stayed low one cycle after a decode read");
      end
      if (!e_valid && op_valid) begin
         report_error("op_valid went high although no decode read was made");
      end
      for (int i = 0; i < NUM_LANES; i++) begin
         if (e_valid) begin
            check_word($sformatf("op_rs_data[%0d]", i), e_rs[i], op_rs_data[i]);
            check_word($sformatf("op_rt_data[%0d]", i), e_rt[i], op_rt_data[i]);
         end
         got_rs[i] = op_rs_data[i];
         got_rt[i] = op_rt_data[i];
      end
      got_preds = preds;
      got_r0    = r0;
      @(posedge clkrst_core_clk);
      model_step();
   endtask

   task automatic put_result(input int lane, input reg_num_t num, input word_t data,
                             input logic pw, input guard_t g);
      ex_valid[lane]      <= 1'b1;
      ex_rd_num[lane]     <= num;
      ex_rd_data[lane]    <= data;
      ex_pred_write[lane] <= pw;
      ex_guard[lane]      <= g;
   endtask

   task automatic clear_ex();
      for (int i = 0; i < NUM_LANES; i++) begin
         ex_valid[i]      <= 1'b0;
         ex_pred_write[i] <= 1'b0;
      end
   endtask

   // One decode read of the same register on every port.
   task automatic read_same(input reg_num_t num);
      for (int i = 0; i < NUM_LANES; i++) begin
         dec_rs_num[i] <= num;
         dec_rt_num[i] <= num;
      end
      dec_valid <= 1'b1;
      tick();
      dec_valid <= 1'b0;
      tick();
   endtask

   task automatic expect_lanes(input string tag, input word_t exp_rs, input word_t exp_rt);
      for (int i = 0; i < NUM_LANES; i++) begin
         check_word($sformatf("%s op_rs_data[%0d]", tag, i), exp_rs, got_rs[i]);
         check_word($sformatf("%s op_rt_data[%0d]", tag, i), exp_rt, got_rt[i]);
      end
   endtask

   task automatic test_reset_state();
      for (int r = 0; r < NUM_REGS; r++) begin
         read_same(reg_num_t'(r));
         expect_lanes($sformatf("reset r%0d", r), '0, '0);
      end
      check_preds("preds", '0, got_preds);
      check_word("r0", '0, got_r0);
   endtask

   task automatic test_distinct_writes();
      put_result(0, 5'd5, 32'h1111_0005, 1'b0, GUARD_ALWAYS);
      put_result(1, 5'd6, 32'h2222_0006, 1'b0, GUARD_ALWAYS);
      put_result(2, 5'd7, 32'h3333_0007, 1'b0, GUARD_ALWAYS);
      put_result(3, 5'd8, 32'h4444_0008, 1'b0, GUARD_ALWAYS);
      tick();
      clear_ex();
      tick();
      read_same(5'd5);
      expect_lanes("r5", 32'h1111_0005, 32'h1111_0005);
      read_same(5'd6);
      expect_lanes("r6", 32'h2222_0006, 32'h2222_0006);
      read_same(5'd7);
      expect_lanes("r7", 32'h3333_0007, 32'h3333_0007);
      read_same(5'd8);
      expect_lanes("r8", 32'h4444_0008, 32'h4444_0008);
   endtask

   task automatic test_same_reg_conflict();
      put_result(0, 5'd4, 32'h0404_0404, 1'b0, GUARD_ALWAYS);
      put_result(1, 5'd9, 32'h0901_0001, 1'b0, GUARD_ALWAYS);
      put_result(2, 5'd9, 32'h0902_0002, 1'b0, GUARD_ALWAYS);
      put_result(3, 5'd9, 32'h0903_0003, 1'b0, GUARD_ALWAYS);
      tick();
      // All four lanes hit register 0.
      put_result(0, 5'd0, 32'hb000_0000, 1'b0, GUARD_ALWAYS);
      put_result(1, 5'd0, 32'hb000_0001, 1'b0, GUARD_ALWAYS);
      put_result(2, 5'd0, 32'hb000_0002, 1'b0, GUARD_ALWAYS);
      put_result(3, 5'd0, 32'hb000_0003, 1'b0, GUARD_ALWAYS);
      tick();
      clear_ex();
      tick();
      read_same(5'd9);
      expect_lanes("r9", 32'h0901_0001, 32'h0901_0001);
      read_same(5'd4);
      expect_lanes("r4", 32'h0404_0404, 32'h0404_0404);
      read_same(5'd0);
      expect_lanes("r0", 32'hb000_0000, 32'hb000_0000);
      check_word("r0", 32'hb000_0000, got_r0);
   endtask

   task automatic test_predicates();
      put_result(0, 5'd1, 32'h0000_0001, 1'b1, GUARD_ALWAYS);
      put_result(1, 5'd2, 32'h0000_0003, 1'b1, GUARD_ALWAYS);
      // Predicate number 3 does not exist.
      put_result(2, 5'd3, 32'h0000_0001, 1'b1, GUARD_ALWAYS);
      tick();
      clear_ex();
      tick();
      tick();
      check_preds("preds", 3'b110, got_preds);
      put_result(0, 5'd10, 32'haaaa_000a, 1'b0, 2'd0);
      put_result(1, 5'd11, 32'hbbbb_000b, 1'b0, 2'd1);
      put_result(2, 5'd12, 32'hcccc_000c, 1'b0, GUARD_ALWAYS);
      put_result(3, 5'd13, 32'hdddd_000d, 1'b0, 2'd2);
      tick();
      clear_ex();
      tick();
      read_same(5'd10);
      expect_lanes("r10", '0, '0);
      read_same(5'd11);
      expect_lanes("r11", 32'hbbbb_000b, 32'hbbbb_000b);
      read_same(5'd12);
      expect_lanes("r12", 32'hcccc_000c, 32'hcccc_000c);
      read_same(5'd13);
      expect_lanes("r13", 32'hdddd_000d, 32'hdddd_000d);
      // Clear predicate 1, and a false guard keeps predicate 2 set.
      put_result(0, 5'd1, 32'h0000_0000, 1'b1, GUARD_ALWAYS);
      put_result(1, 5'd2, 32'h0000_0000, 1'b1, 2'd0);
      tick();
      clear_ex();
      tick();
      tick();
      check_preds("preds", 3'b100, got_preds);
   endtask

   task automatic test_forwarding();
      put_result(0, 5'd20, 32'h2000_0000, 1'b0, GUARD_ALWAYS);
      put_result(1, 5'd21, 32'h2100_0001, 1'b0, GUARD_ALWAYS);
      put_result(2, 5'd20, 32'h2000_0002, 1'b0, GUARD_ALWAYS);
      put_result(3, 5'd21, 32'h2100_0003, 1'b0, GUARD_ALWAYS);
      tick();
      clear_ex();
      // Read while the writes are still in writeback.
      for (int i = 0; i < NUM_LANES; i++) begin
         dec_rs_num[i] <= 5'd20;
         dec_rt_num[i] <= 5'd21;
      end
      dec_valid <= 1'b1;
      tick();
      dec_valid <= 1'b0;
      tick();
      expect_lanes("forward", 32'h2000_0000, 32'h2100_0001);
   endtask

   task automatic test_random();
      for (int n = 0; n < 200; n++) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            ex_valid[i]      <= 1'($urandom_range(0, 1));
            ex_rd_num[i]     <= reg_num_t'($urandom_range(0, 7));
            ex_rd_data[i]    <= $urandom;
            ex_pred_write[i] <= ($urandom_range(0, 5) == 0);
            ex_guard[i]      <= guard_t'($urandom_range(0, 3));
            dec_rs_num[i]    <= reg_num_t'($urandom_range(0, 7));
            dec_rt_num[i]    <= reg_num_t'($urandom_range(0, 7));
         end
         dec_valid <= 1'($urandom_range(0, 1));
         tick();
      end
      clear_ex();
      dec_valid <= 1'b0;
      tick();
      tick();
   endtask

   initial begin
      void'($urandom(55));
      clkrst_core_rst_n = 1'b0;
      dec_valid = 1'b0;
      e_valid = 1'b0;
      m_preds = '0;
      for (int i = 0; i < NUM_LANES; i++) begin
         ex_valid[i] = 1'b0;
         ex_rd_num[i] = '0;
         ex_rd_data[i] = '0;
         ex_pred_write[i] = 1'b0;
         ex_guard[i] = GUARD_ALWAYS;
         dec_rs_num[i] = '0;
         dec_rt_num[i] = '0;
         p_rd_we[i] = 1'b0;
         p_pred_we[i] = 1'b0;
      end
      for (int r = 0; r < NUM_REGS; r++) begin
         m_regs[r] = '0;
      end
      repeat (2) @(posedge clkrst_core_clk);
      clkrst_core_rst_n <= 1'b1;
      test_reset_state();
      test_distinct_writes();
      test_same_reg_conflict();
      test_predicates();
      test_forwarding();
      test_random();
      pass_printed = 1'b1;
      $display("test passed");
      $finish;
   end

   // A run stopped by a failed assertion still ends with the verdict.
   final begin
      if (!pass_printed && !fail_reported) begin
         $display("test failed");
      end
   end

endmodule

//--- vlog.f
mcpu_core_pkg.sv
mcpu_core_writeback.sv
mcpu_core_regfile.sv
mcpu_core_operand_fetch.sv
mcpu_core_regs_top.sv
mcpu_core_regs_properties.sv
tb_mcpu_core_regs.sv

//--- run.sh
#!/bin/sh
# Build the register slice testbench with Verilator and run it.
# The exit status is nonzero when the simulation reports a failure.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_mcpu_core_regs -o tb_sim &&
./obj_dir/tb_sim || {
   echo "simulation run did not complete cleanly"
   exit 1
}
